/* verilog/l2_cache_macros.svh */
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// byte offset within a 256-bit line.
`define L2_S_OFFSET 5

// set index bits.
`define L2_S_INDEX 3

`define L2_NUM_SETS (1 << `L2_S_INDEX)

// rest of the 32-bit address.
`define L2_S_TAG (32 - `L2_S_OFFSET - `L2_S_INDEX)

`endif

/* verilog/l2_cache_types.sv */
`include "l2_cache_macros.svh"

package l2_cache_types;

    typedef logic [31:0]                       addr_t;
    typedef logic [`L2_S_TAG-1:0]              tag_t;
    typedef logic [`L2_S_INDEX-1:0]            index_t;
    typedef logic [8*(2**`L2_S_OFFSET)-1:0]    line_t;
    typedef logic [(2**`L2_S_OFFSET)-1:0]      byte_mask_t;

    typedef struct packed {
        logic       read;
        logic       write;
        addr_t      address;
        byte_mask_t byte_enable;   // one bit per byte of the line.
        line_t      wdata;
    } l2_cpu_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } l2_cpu_rsp_t;

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;            // line aligned.
        line_t wdata;
    } l2_pmem_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } l2_pmem_rsp_t;

endpackage : l2_cache_types

/* verilog/cache_mux_types.sv */
`include "l2_cache_macros.svh"

package cache_mux_types;

    typedef enum logic [1:0] {
        no_write,
        cpu_write_cache,
        mem_write_cache
    } dataarraymux_sel_t;

    typedef enum logic {
        cache_read_mem,
        cache_write_mem
    } pmemaddressmux_sel_t;

    typedef enum logic [1:0] {
        s_check,
        s_writeback,
        s_fetch,
        s_fill
    } l2_state_t;

    typedef struct packed {
        logic              valid_load;
        logic              valid_in;
        logic              dirty_load;
        logic              dirty_in;
        logic              tag_load;
        dataarraymux_sel_t write_sel;
    } l2_way_ctrl_t;

    typedef struct packed {
        l2_way_ctrl_t [1:0]  way;
        logic                lru_load;
        logic                lru_in;       // way to evict next.
        logic                buffer_load;
        logic                dataout_sel;
        pmemaddressmux_sel_t pmem_addr_sel;
    } l2_ctrl_t;

    typedef struct packed {
        logic       hit;
        logic [1:0] way_hit;
        logic       lru;
        logic [1:0] valid;
        logic [1:0] dirty;
    } l2_status_t;

endpackage : cache_mux_types

/* verilog/l2_way.sv */
`timescale 1ns/100ps
`include "l2_cache_macros.svh"

module l2_way
(
    input  logic                         clk,
    input  logic                         reset,
    input  l2_cache_types::index_t       index,
    input  l2_cache_types::tag_t         tag,
    input  cache_mux_types::l2_way_ctrl_t way_ctrl,
    input  l2_cache_types::line_t        cpu_wdata,
    input  l2_cache_types::byte_mask_t   byte_enable,
    input  l2_cache_types::line_t        fill_data,
    output l2_cache_types::line_t        rdata,
    output l2_cache_types::tag_t         tag_out,
    output logic                         valid,
    output logic                         dirty,
    output logic                         way_hit
);

    logic [`L2_NUM_SETS-1:0]    valid_array;
    logic [`L2_NUM_SETS-1:0]    dirty_array;
    l2_cache_types::tag_t       tag_array [`L2_NUM_SETS];
    l2_cache_types::line_t      data_array [`L2_NUM_SETS];
    l2_cache_types::byte_mask_t write_en;
    l2_cache_types::line_t      write_data;

    always_comb
    begin
        case (way_ctrl.write_sel)
            cache_mux_types::cpu_write_cache:
            begin
                write_en   = byte_enable;
                write_data = cpu_wdata;
            end
            cache_mux_types::mem_write_cache:
            begin
                write_en   = '1;          // whole line from the buffer.
                write_data = fill_data;
            end
            default:
            begin
                write_en   = '0;
                write_data = cpu_wdata;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_array <= '0;
            dirty_array <= '0;
        end
        else
        begin
            if (way_ctrl.valid_load)
                valid_array[index] <= way_ctrl.valid_in;
            if (way_ctrl.dirty_load)
                dirty_array[index] <= way_ctrl.dirty_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (way_ctrl.tag_load)
            tag_array[index] <= tag;
        for (int i = 0; i < $bits(l2_cache_types::byte_mask_t); i++)
        begin
            if (write_en[i])
                data_array[index][8*i +: 8] <= write_data[8*i +: 8];
        end
    end

    assign rdata   = data_array[index];
    assign tag_out = tag_array[index];
    assign valid   = valid_array[index];
    assign dirty   = dirty_array[index];
    assign way_hit = valid && (tag_out == tag);

endmodule : l2_way

/* verilog/l2_cache_datapath.sv */
`timescale 1ns/100ps
`include "l2_cache_macros.svh"

module l2_cache_datapath
(
    input  logic                         clk,
    input  logic                         reset,
    input  l2_cache_types::l2_cpu_req_t  cpu_req,
    input  l2_cache_types::line_t        pmem_rdata,
    input  cache_mux_types::l2_ctrl_t    ctrl,
    output l2_cache_types::line_t        cpu_rdata,
    output l2_cache_types::addr_t        pmem_address,
    output l2_cache_types::line_t        pmem_wdata,
    output cache_mux_types::l2_status_t  status
);

    l2_cache_types::tag_t    tag;
    l2_cache_types::index_t  index;
    l2_cache_types::line_t   mem_buffer;
    l2_cache_types::line_t   way_rdata [2];
    l2_cache_types::tag_t    way_tag [2];
    l2_cache_types::line_t   dataout;
    logic [1:0]              way_valid;
    logic [1:0]              way_dirty;
    logic [1:0]              way_hit;
    logic [`L2_NUM_SETS-1:0] lru_array;

    assign tag   = cpu_req.address[31 -: `L2_S_TAG];
    assign index = cpu_req.address[`L2_S_OFFSET +: `L2_S_INDEX];

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        l2_way way_i
        (
            .clk         (clk),
            .reset       (reset),
            .index       (index),
            .tag         (tag),
            .way_ctrl    (ctrl.way[w]),
            .cpu_wdata   (cpu_req.wdata),
            .byte_enable (cpu_req.byte_enable),
            .fill_data   (mem_buffer),
            .rdata       (way_rdata[w]),
            .tag_out     (way_tag[w]),
            .valid       (way_valid[w]),
            .dirty       (way_dirty[w]),
            .way_hit     (way_hit[w])
        );
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.buffer_load)
            mem_buffer <= pmem_rdata;   // memory line held for the fill.
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            lru_array <= '0;
        else if (ctrl.lru_load)
            lru_array[index] <= ctrl.lru_in;
    end

    assign dataout    = way_rdata[ctrl.dataout_sel];
    assign cpu_rdata  = dataout;
    assign pmem_wdata = dataout;

    always_comb
    begin
        case (ctrl.pmem_addr_sel)
            cache_mux_types::cache_write_mem:
                pmem_address = {way_tag[ctrl.dataout_sel], index, {`L2_S_OFFSET{1'b0}}};
            default:
                pmem_address = {tag, index, {`L2_S_OFFSET{1'b0}}};
        endcase
    end

    assign status = '{
        hit:     |way_hit,
        way_hit: way_hit,
        lru:     lru_array[index],
        valid:   way_valid,
        dirty:   way_dirty
    };

endmodule : l2_cache_datapath

/* verilog/l2_cache_control.sv */
`timescale 1ns/100ps

module l2_cache_control
(
    input  logic                         clk,
    input  logic                         reset,
    input  l2_cache_types::l2_cpu_req_t  cpu_req,
    input  cache_mux_types::l2_status_t  status,
    input  logic                         pmem_resp,
    output cache_mux_types::l2_ctrl_t    ctrl,
    output logic                         cpu_resp,
    output logic                         pmem_read,
    output logic                         pmem_write
);

    cache_mux_types::l2_state_t state;
    cache_mux_types::l2_state_t next_state;
    logic                       victim;
    logic                       hit_way;

    assign victim  = status.lru;
    assign hit_way = status.way_hit[1];   // way 0 unless way 1 hits.

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= cache_mux_types::s_check;
        else
            state <= next_state;
    end

    always_comb
    begin
        ctrl       = '0;
        cpu_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        next_state = state;
        case (state)
            cache_mux_types::s_check:
            begin
                if (cpu_req.read || cpu_req.write)
                begin
                    if (status.hit)
                    begin
                        cpu_resp         = 1'b1;
                        ctrl.dataout_sel = hit_way;
                        ctrl.lru_load    = 1'b1;
                        ctrl.lru_in      = ~hit_way;
                        if (cpu_req.write)
                        begin
                            ctrl.way[hit_way].write_sel  = cache_mux_types::cpu_write_cache;
                            ctrl.way[hit_way].dirty_load = 1'b1;
                            ctrl.way[hit_way].dirty_in   = 1'b1;
                        end
                    end
                    else if (status.valid[victim] && status.dirty[victim])
                        next_state = cache_mux_types::s_writeback;
                    else
                        next_state = cache_mux_types::s_fetch;
                end
            end
            cache_mux_types::s_writeback:
            begin
                pmem_write         = 1'b1;
                ctrl.dataout_sel   = victim;
                ctrl.pmem_addr_sel = cache_mux_types::cache_write_mem;
                if (pmem_resp)
                    next_state = cache_mux_types::s_fetch;
            end
            cache_mux_types::s_fetch:
            begin
                pmem_read          = 1'b1;
                ctrl.pmem_addr_sel = cache_mux_types::cache_read_mem;
                ctrl.buffer_load   = pmem_resp;
                if (pmem_resp)
                    next_state = cache_mux_types::s_fill;
            end
            cache_mux_types::s_fill:
            begin
                ctrl.way[victim].write_sel  = cache_mux_types::mem_write_cache;
                ctrl.way[victim].valid_load = 1'b1;
                ctrl.way[victim].valid_in   = 1'b1;
                ctrl.way[victim].dirty_load = 1'b1;
                ctrl.way[victim].dirty_in   = 1'b0;   // clean copy of memory.
                ctrl.way[victim].tag_load   = 1'b1;
                next_state = cache_mux_types::s_check;
            end
            default:
                next_state = cache_mux_types::s_check;
        endcase
    end

endmodule : l2_cache_control

/* verilog/l2_cache.sv */
`timescale 1ns/100ps

module l2_cache
(
    input  logic                         clk,
    input  logic                         reset,
    input  l2_cache_types::l2_cpu_req_t  cpu_req,
    input  l2_cache_types::l2_pmem_rsp_t pmem_rsp,
    output l2_cache_types::l2_cpu_rsp_t  cpu_rsp,
    output l2_cache_types::l2_pmem_req_t pmem_req
);

    cache_mux_types::l2_ctrl_t   ctrl;
    cache_mux_types::l2_status_t status;

    l2_cache_datapath datapath_i
    (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .pmem_rdata   (pmem_rsp.rdata),
        .ctrl         (ctrl),
        .cpu_rdata    (cpu_rsp.rdata),
        .pmem_address (pmem_req.address),
        .pmem_wdata   (pmem_req.wdata),
        .status       (status)
    );

    l2_cache_control control_i
    (
        .clk        (clk),
        .reset      (reset),
        .cpu_req    (cpu_req),
        .status     (status),
        .pmem_resp  (pmem_rsp.resp),
        .ctrl       (ctrl),
        .cpu_resp   (cpu_rsp.resp),
        .pmem_read  (pmem_req.read),
        .pmem_write (pmem_req.write)
    );

endmodule : l2_cache

/* tb/l2_pmem_model.sv */
`timescale 1ns/100ps

module l2_pmem_model
(
    input  logic                         clk,
    input  logic                         reset,
    input  l2_cache_types::l2_pmem_req_t pmem_req,
    output l2_cache_types::l2_pmem_rsp_t pmem_rsp
);

    l2_cache_types::line_t mem [32];   // by address bits 9:5.
    logic [31:0]           written;
    logic [4:0]            slot;
    logic                  busy;
    int unsigned           wait_cycles;

    // untouched lines read as a pattern of the whole address.
    function automatic l2_cache_types::line_t fill_line(l2_cache_types::addr_t addr);
        l2_cache_types::line_t line;
        for (int w = 0; w < 8; w++)
            line[32*w +: 32] = (addr + 32'(w) * 32'h0101_0004) ^ 32'hC3A5_96E1;
        return line;
    endfunction

    assign slot = pmem_req.address[9:5];

    initial
    begin
        pmem_rsp = '0;
        busy     = 1'b0;
        written  = '0;
    end

    always @(posedge clk)
    begin
        if (reset || pmem_rsp.resp)
        begin
            pmem_rsp.resp <= 1'b0;
            busy          <= 1'b0;
        end
        else if (pmem_req.read || pmem_req.write)
        begin
            if (!busy)
            begin
                busy        <= 1'b1;
                wait_cycles <= $urandom_range(3, 0);   // 1 to 4 cycles.
            end
            else if (wait_cycles != 0)
                wait_cycles <= wait_cycles - 1;
            else
            begin
                pmem_rsp.resp  <= 1'b1;
                pmem_rsp.rdata <= written[slot] ? mem[slot] : fill_line(pmem_req.address);
                if (pmem_req.write)
                begin
                    mem[slot]     <= pmem_req.wdata;
                    written[slot] <= 1'b1;
                end
            end
        end
    end

endmodule : l2_pmem_model

/* tb/l2_cache_tb.sv */
`timescale 1ns/100ps
`include "l2_cache_macros.svh"

module l2_cache_tb;

    localparam int          NUM_OPS = 309;
    localparam logic [31:0] BASE    = 32'h1234_5000;   // 4 tags x 8 sets above this.

    logic                         clk = 1'b0;
    logic                         reset;
    l2_cache_types::l2_cpu_req_t  cpu_req;
    l2_cache_types::l2_cpu_rsp_t  cpu_rsp;
    l2_cache_types::l2_pmem_req_t pmem_req;
    l2_cache_types::l2_pmem_rsp_t pmem_rsp;
    l2_cache_types::line_t        shadow [32];
    l2_cache_types::line_t        exp_line;
    l2_cache_types::addr_t        last_rd_addr;
    l2_cache_types::addr_t        last_wb_addr;
    logic                         exp_read;
    string                        test_name;
    int                           errors = 0;
    int                           tests_failed = 0;
    int                           rd_count = 0;
    int                           wb_count = 0;
    int                           err_mark;
    int                           rd_mark;
    int                           wb_mark;

    l2_cache l2_cache_i
    (
        .clk      (clk),
        .reset    (reset),
        .cpu_req  (cpu_req),
        .pmem_rsp (pmem_rsp),
        .cpu_rsp  (cpu_rsp),
        .pmem_req (pmem_req)
    );

    l2_pmem_model pmem_i
    (
        .clk      (clk),
        .reset    (reset),
        .pmem_req (pmem_req),
        .pmem_rsp (pmem_rsp)
    );

    always #5 clk = ~clk;

    function automatic l2_cache_types::addr_t line_addr(int t, int set);
        return BASE | (32'(t) << (`L2_S_OFFSET + `L2_S_INDEX)) | (32'(set) << `L2_S_OFFSET);
    endfunction

    function automatic l2_cache_types::line_t initial_line(l2_cache_types::addr_t addr);
        l2_cache_types::line_t line;
        for (int w = 0; w < 8; w++)
            line[32*w +: 32] = (addr + 32'(w) * 32'h0101_0004) ^ 32'hC3A5_96E1;
        return line;
    endfunction

    function automatic l2_cache_types::line_t random_line();
        l2_cache_types::line_t line;
        for (int w = 0; w < 8; w++)
            line[32*w +: 32] = $urandom;
        return line;
    endfunction

    // shadow memory with CPU writes merged per byte.
    function automatic l2_cache_types::line_t ref_access(logic write,
        l2_cache_types::addr_t addr, l2_cache_types::byte_mask_t mask,
        l2_cache_types::line_t wdata);
        for (int i = 0; i < 32; i++)
            if (write && mask[i])
                shadow[addr[9:5]][8*i +: 8] = wdata[8*i +: 8];
        return shadow[addr[9:5]];
    endfunction

    task automatic access(logic write, l2_cache_types::addr_t addr,
        l2_cache_types::byte_mask_t mask, l2_cache_types::line_t wdata);
        exp_read = ~write;
        exp_line = ref_access(write, addr, mask, wdata);
        cpu_req  = '{read: ~write, write: write, address: addr, byte_enable: mask,
                     wdata: wdata};
        do
            @(posedge clk);
        while (!cpu_rsp.resp);
        @(negedge clk);
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;
    endtask

    task automatic check_count(string what, int expected, int actual);
        if (expected != actual)
        begin
            $display("Error: %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        err_mark  = errors;
        rd_mark   = rd_count;
        wb_mark   = wb_count;
    endtask

    task automatic end_test();
        if (errors == err_mark)
            $display("test %s: ok", test_name);
        else
        begin
            $display("test %s: %0d errors", test_name, errors - err_mark);
            tests_failed++;
        end
    endtask

    always @(posedge clk)
    begin
        if (!reset && cpu_rsp.resp && exp_read && cpu_rsp.rdata !== exp_line)
        begin
            $display("Error: %s: expected %h actual %h", test_name, exp_line, cpu_rsp.rdata);
            errors++;
        end
        if (!reset && pmem_req.read && pmem_rsp.resp)
        begin
            rd_count++;
            last_rd_addr = pmem_req.address;
        end
        if (!reset && pmem_req.write && pmem_rsp.resp)
        begin
            wb_count++;
            last_wb_addr = pmem_req.address;
            if ((pmem_req.address & ~32'h3E0) != BASE)
            begin
                $display("writeback to %h lies outside the tested lines", pmem_req.address);
                errors++;
            end
            if (pmem_req.wdata !== shadow[pmem_req.address[9:5]])
            begin
                $display("Error: %s writeback: expected %h actual %h", test_name,
                         shadow[pmem_req.address[9:5]], pmem_req.wdata);
                errors++;
            end
        end
    end

    initial
    begin
        void'($urandom(77));
        reset    = 1'b1;
        cpu_req  = '0;
        exp_read = 1'b0;
        exp_line = '0;
        for (int i = 0; i < 32; i++)
            shadow[i] = initial_line(BASE | (32'(i) << `L2_S_OFFSET));
        repeat (3) @(negedge clk);
        reset = 1'b0;

        start_test("reset");
        repeat (4)
        begin
            @(posedge clk);
            if (cpu_rsp.resp || pmem_req.read || pmem_req.write)
            begin
                $display("cache output active after reset with no request");
                errors++;
            end
        end
        @(negedge clk);
        end_test();

        start_test("miss_then_hit");
        access(1'b0, line_addr(0, 1), '0, '0);
        check_count("pmem reads on miss", 1, rd_count - rd_mark);
        if (last_rd_addr !== line_addr(0, 1))
        begin
            $display("Error: %s read address: expected %h actual %h", test_name,
                     line_addr(0, 1), last_rd_addr);
            errors++;
        end
        access(1'b0, line_addr(0, 1), '0, '0);
        check_count("pmem reads in total", 1, rd_count - rd_mark);
        end_test();

        start_test("byte_mask");
        access(1'b1, line_addr(1, 2), $urandom, random_line());
        access(1'b0, line_addr(1, 2), '0, '0);
        end_test();

        start_test("lru_writeback");
        access(1'b1, line_addr(0, 5), $urandom, random_line());
        access(1'b0, line_addr(1, 5), '0, '0);
        access(1'b0, line_addr(0, 5), '0, '0);
        access(1'b0, line_addr(2, 5), '0, '0);
        check_count("writebacks on clean eviction", 0, wb_count - wb_mark);
        access(1'b0, line_addr(3, 5), '0, '0);
        check_count("writebacks on dirty eviction", 1, wb_count - wb_mark);
        if (last_wb_addr !== line_addr(0, 5))
        begin
            $display("Error: %s writeback address: expected %h actual %h", test_name,
                     line_addr(0, 5), last_wb_addr);
            errors++;
        end
        end_test();

        start_test("random");
        repeat (300)
        begin
            if ($urandom_range(1, 0))
                access(1'b1, line_addr($urandom_range(3, 0), $urandom_range(7, 0)),
                       $urandom, random_line());
            else
                access(1'b0, line_addr($urandom_range(3, 0), $urandom_range(7, 0)), '0, '0);
        end
        end_test();

        $display("tests: 5 run, %0d failed, %0d errors, %0d pmem reads, %0d writebacks",
                 tests_failed, errors, rd_count, wb_count);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        #(NUM_OPS * 20 * 10 * 2);
        $display("watchdog expired after %0d ns, the cache stopped responding", NUM_OPS * 400);
        $display("** FAIL **");
        $finish;
    end

endmodule : l2_cache_tb

/* filelist.f */
+incdir+verilog
verilog/l2_cache_types.sv
verilog/cache_mux_types.sv
verilog/l2_way.sv
verilog/l2_cache_datapath.sv
verilog/l2_cache_control.sv
verilog/l2_cache.sv
tb/l2_pmem_model.sv
tb/l2_cache_tb.sv

/* Bender.yml */
package:
  name: l2_cache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/l2_cache_types.sv
      - verilog/cache_mux_types.sv
      - verilog/l2_way.sv
      - verilog/l2_cache_datapath.sv
      - verilog/l2_cache_control.sv
      - verilog/l2_cache.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/l2_pmem_model.sv
      - tb/l2_cache_tb.sv
